//--- common/frontend_pkg.sv
// Front end shared definitions: widths, opcodes, bus commands, credit depth
`default_nettype none

package frontend_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int ADDR_WIDTH     = 64;  // Byte address
  localparam int INST_WIDTH     = 32;
  localparam int LINE_WIDTH     = 64;  // Cache line and memory data
  localparam int REG_IDX_WIDTH  = 5;
  localparam int ALU_FUNC_WIDTH = 5;

  // Direct-mapped cache geometry, index is addr[9:3], tag is addr[31:10]
  localparam int INDEX_WIDTH = 7;
  localparam int TAG_WIDTH   = 22;

  // Memory transaction tag, zero means not accepted
  localparam int MEM_TAG_WIDTH = 4;

  ////////////////////////////////////////////////////////////////////////////
  // Architectural constants
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [REG_IDX_WIDTH-1:0] ZERO_REG = 5'd31;

  // Alpha noop, loaded into IF/ID by reset
  localparam logic [INST_WIDTH-1:0] NOOP_INST = 32'h47ff_041f;

  // Memory bus commands
  typedef enum logic [1:0] {
    BUS_NONE = 2'h0,
    BUS_LOAD = 2'h1
  } bus_cmd_t;

  ////////////////////////////////////////////////////////////////////////////
  // Opcodes, bits 31:26 of the instruction
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [5:0] OP_PAL         = 6'h00;  // Halt when rest is zero
  localparam logic [5:0] OP_INTOP       = 6'h10;
  localparam logic [5:0] OP_LDQ         = 6'h29;
  localparam logic [5:0] OP_STQ         = 6'h2D;
  localparam logic [5:0] OP_BR          = 6'h30;
  localparam logic [5:0] OP_BCOND_FIRST = 6'h38;  // Range runs to 6'h3F

  // Dispatch credits held after reset
  localparam int DEFAULT_CREDITS = 4;

endpackage

`default_nettype wire

//--- icache/icache_mem.sv
// Instruction cache arrays: line data, tags and valid bits, combinational lookup
`timescale 1ns/1ps
`default_nettype none

module icache_mem (
  input  logic                                  clock,
  input  logic                                  reset,
  input  logic                                  wr_en,
  input  logic [frontend_pkg::INDEX_WIDTH-1:0]  wr_idx,
  input  logic [frontend_pkg::TAG_WIDTH-1:0]    wr_tag,
  input  logic [frontend_pkg::LINE_WIDTH-1:0]   wr_data,
  input  logic [frontend_pkg::INDEX_WIDTH-1:0]  rd_idx,
  input  logic [frontend_pkg::TAG_WIDTH-1:0]    rd_tag,
  output logic [frontend_pkg::LINE_WIDTH-1:0]   rd_data,
  output logic                                  rd_valid
);

  localparam int LINES = 2 ** frontend_pkg::INDEX_WIDTH;  // 128 lines

  logic [frontend_pkg::LINE_WIDTH-1:0] data_array [LINES];
  logic [frontend_pkg::TAG_WIDTH-1:0]  tag_array  [LINES];
  logic [LINES-1:0]                    valid_bits;

  // Lookup, hit needs a valid line with matching tag
  assign rd_data  = data_array[rd_idx];
  assign rd_valid = valid_bits[rd_idx] && (tag_array[rd_idx] == rd_tag);

  // Valid bits, cleared by reset
  always_ff @(posedge clock)
  begin
    if (reset)
      valid_bits <= '0;
    else if (wr_en)
      valid_bits[wr_idx] <= 1'b1;     // Line filled
  end

  // Line and tag storage
  always_ff @(posedge clock)
  begin
    if (wr_en)
    begin
      data_array[wr_idx] <= wr_data;
      tag_array[wr_idx]  <= wr_tag;
    end
  end

endmodule

`default_nettype wire

//--- icache/icache_ctrl.sv
// Instruction cache controller: hit check, miss request and fill on the memory bus
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
  input  logic                                    clock,
  input  logic                                    reset,
  input  logic [frontend_pkg::ADDR_WIDTH-1:0]     fetch_addr,
  input  logic [frontend_pkg::MEM_TAG_WIDTH-1:0]  mem2proc_response,
  input  logic [frontend_pkg::MEM_TAG_WIDTH-1:0]  mem2proc_tag,
  output frontend_pkg::bus_cmd_t                  proc2mem_command,
  output logic [frontend_pkg::ADDR_WIDTH-1:0]     proc2mem_addr,
  output logic [frontend_pkg::INDEX_WIDTH-1:0]    cache_rd_idx,
  output logic [frontend_pkg::TAG_WIDTH-1:0]      cache_rd_tag,
  input  logic                                    cache_rd_valid,
  input  logic [frontend_pkg::LINE_WIDTH-1:0]     cache_rd_data,
  output logic                                    cache_wr_en,
  output logic [frontend_pkg::INDEX_WIDTH-1:0]    cache_wr_idx,
  output logic [frontend_pkg::TAG_WIDTH-1:0]      cache_wr_tag,
  output logic [frontend_pkg::LINE_WIDTH-1:0]     line_data,
  output logic                                    line_valid
);

  localparam int IDX_LSB = 3;                                   // Byte offset in line
  localparam int TAG_LSB = IDX_LSB + frontend_pkg::INDEX_WIDTH;  // Bit 10
  localparam int TAG_MSB = TAG_LSB + frontend_pkg::TAG_WIDTH - 1;  // Bit 31

  logic                                    miss_pending;  // One fill outstanding
  logic [frontend_pkg::MEM_TAG_WIDTH-1:0]  pend_mem_tag;  // Tag memory gave us
  logic [frontend_pkg::INDEX_WIDTH-1:0]    pend_idx;
  logic [frontend_pkg::TAG_WIDTH-1:0]      pend_ctag;
  logic                                    want_line;
  logic                                    req_accepted;
  logic                                    fill_arrives;

  ////////////////////////////////////////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////////////////////////////////////////

  assign cache_rd_idx = fetch_addr[TAG_LSB-1:IDX_LSB];
  assign cache_rd_tag = fetch_addr[TAG_MSB:TAG_LSB];
  assign line_data    = cache_rd_data;
  assign line_valid   = cache_rd_valid;   // Hit in the same cycle

  ////////////////////////////////////////////////////////////////////////////
  // Miss request, repeats every cycle while memory answers busy
  ////////////////////////////////////////////////////////////////////////////

  // No request while held in reset or while a fill is owed
  assign want_line    = !reset && !cache_rd_valid && !miss_pending;
  assign req_accepted = want_line && (mem2proc_response != '0);

  assign proc2mem_command = want_line ? frontend_pkg::BUS_LOAD : frontend_pkg::BUS_NONE;
  // Line aligned, upper half zero
  assign proc2mem_addr    = {{(frontend_pkg::ADDR_WIDTH - TAG_MSB - 1){1'b0}},
                             fetch_addr[TAG_MSB:IDX_LSB], {IDX_LSB{1'b0}}};

  // Matching return tag, line written at the next edge
  assign fill_arrives = miss_pending && (mem2proc_tag == pend_mem_tag);
  assign cache_wr_en  = fill_arrives;
  assign cache_wr_idx = pend_idx;
  assign cache_wr_tag = pend_ctag;

  always_ff @(posedge clock)
  begin
    if (reset)
      miss_pending <= 1'b0;
    else if (req_accepted)
      miss_pending <= 1'b1;
    else if (fill_arrives)
      miss_pending <= 1'b0;           // Hit follows next cycle
  end

  // Where the fill goes
  always_ff @(posedge clock)
  begin
    if (req_accepted)
    begin
      pend_mem_tag <= mem2proc_response;
      pend_idx     <= cache_rd_idx;
      pend_ctag    <= cache_rd_tag;
    end
  end

endmodule

`default_nettype wire

//--- logic/fetch_stage.sv
// Fetch stage: sequential program counter, word select and IF/ID register
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
  input  logic                                 clock,
  input  logic                                 reset,
  input  logic [frontend_pkg::LINE_WIDTH-1:0]  line_data,
  input  logic                                 line_valid,
  input  logic                                 if_id_enable,
  output logic [frontend_pkg::ADDR_WIDTH-1:0]  fetch_addr,
  output logic                                 if_id_valid,
  output logic [frontend_pkg::ADDR_WIDTH-1:0]  if_id_npc,
  output logic [frontend_pkg::INST_WIDTH-1:0]  if_id_ir
);

  localparam logic [frontend_pkg::ADDR_WIDTH-1:0] INST_BYTES = 4;

  logic [frontend_pkg::ADDR_WIDTH-1:0] pc;
  logic [frontend_pkg::ADDR_WIDTH-1:0] next_pc;
  logic [frontend_pkg::INST_WIDTH-1:0] fetch_word;
  logic                                advance;

  assign fetch_addr = pc;
  assign next_pc    = pc + INST_BYTES;
  assign advance    = line_valid && if_id_enable;  // Word taken this cycle

  // Two instructions per line, PC bit 2 picks the half
  assign fetch_word = pc[2] ? line_data[2*frontend_pkg::INST_WIDTH-1:frontend_pkg::INST_WIDTH]
                            : line_data[frontend_pkg::INST_WIDTH-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Program counter, straight line from zero
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    if (reset)
      pc <= '0;
    else if (advance)
      pc <= next_pc;                  // Stops on a miss or a stall
  end

  ////////////////////////////////////////////////////////////////////////////
  // IF/ID register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      if_id_valid <= 1'b0;
      if_id_npc   <= '0;
      if_id_ir    <= frontend_pkg::NOOP_INST;
    end
    else if (advance)
    begin
      if_id_valid <= 1'b1;
      if_id_npc   <= next_pc;
      if_id_ir    <= fetch_word;
    end
    else if (if_id_enable)
    begin
      // Line missing, insert a bubble
      if_id_valid <= 1'b0;
      if_id_ir    <= frontend_pkg::NOOP_INST;
    end
  end

endmodule

`default_nettype wire

//--- logic/decode_stage.sv
// Decode stage: field and control decode, ID/DP register and dispatch pulse
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  logic                                     clock,
  input  logic                                     reset,
  input  logic                                     if_id_valid,
  input  logic [frontend_pkg::ADDR_WIDTH-1:0]      if_id_npc,
  input  logic [frontend_pkg::INST_WIDTH-1:0]      if_id_ir,
  input  logic                                     credit_available,
  output logic                                     if_id_enable,
  output logic                                     dp_valid,
  output logic [frontend_pkg::ADDR_WIDTH-1:0]      dp_npc,
  output logic [frontend_pkg::INST_WIDTH-1:0]      dp_ir,
  output logic [frontend_pkg::REG_IDX_WIDTH-1:0]   dp_rega_idx,
  output logic [frontend_pkg::REG_IDX_WIDTH-1:0]   dp_regb_idx,
  output logic [frontend_pkg::REG_IDX_WIDTH-1:0]   dp_dest_idx,
  output logic [frontend_pkg::ALU_FUNC_WIDTH-1:0]  dp_alu_func,
  output logic                                     dp_rd_mem,
  output logic                                     dp_wr_mem,
  output logic                                     dp_cond_branch,
  output logic                                     dp_uncond_branch,
  output logic                                     dp_halt,
  output logic                                     dp_illegal
);

  logic [5:0]                               opcode;
  logic [frontend_pkg::REG_IDX_WIDTH-1:0]   ra_idx;
  logic [frontend_pkg::REG_IDX_WIDTH-1:0]   rb_idx;
  logic [frontend_pkg::REG_IDX_WIDTH-1:0]   dec_dest;
  logic [frontend_pkg::ALU_FUNC_WIDTH-1:0]  dec_alu_func;
  logic dec_rd_mem, dec_wr_mem, dec_cond, dec_uncond, dec_halt, dec_illegal;
  logic fire;

  assign opcode = if_id_ir[31:26];
  assign ra_idx = if_id_ir[25:21];
  assign rb_idx = if_id_ir[20:16];

  // Hold IF/ID only when a valid instruction has no credit
  assign fire         = if_id_valid && credit_available;
  assign if_id_enable = !if_id_valid || credit_available;

  ////////////////////////////////////////////////////////////////////////////
  // Decoder
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    dec_dest     = frontend_pkg::ZERO_REG;   // Most classes write nothing
    dec_alu_func = '0;
    dec_rd_mem   = 1'b0;
    dec_wr_mem   = 1'b0;
    dec_cond     = 1'b0;
    dec_uncond   = 1'b0;
    dec_halt     = 1'b0;
    dec_illegal  = 1'b0;
    case (opcode) inside
      frontend_pkg::OP_PAL:
      begin
        dec_halt    = (if_id_ir[25:0] == '0);
        dec_illegal = (if_id_ir[25:0] != '0);  // Other PAL calls unsupported
      end
      frontend_pkg::OP_INTOP:
      begin
        dec_dest     = if_id_ir[4:0];
        dec_alu_func = if_id_ir[9:5];
      end
      frontend_pkg::OP_LDQ:
      begin
        dec_dest   = ra_idx;
        dec_rd_mem = 1'b1;
      end
      frontend_pkg::OP_STQ:   dec_wr_mem = 1'b1;
      frontend_pkg::OP_BR:
      begin
        dec_dest   = ra_idx;              // Link register
        dec_uncond = 1'b1;
      end
      [frontend_pkg::OP_BCOND_FIRST:6'h3F]: dec_cond = 1'b1;
      default:                dec_illegal = 1'b1;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // ID/DP register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    if (reset)
      dp_valid <= 1'b0;
    else
      dp_valid <= fire;               // One cycle per instruction
  end

  always_ff @(posedge clock)
  begin
    if (fire)
    begin
      dp_npc           <= if_id_npc;
      dp_ir            <= if_id_ir;
      dp_rega_idx      <= ra_idx;
      dp_regb_idx      <= rb_idx;
      dp_dest_idx      <= dec_dest;
      dp_alu_func      <= dec_alu_func;
      dp_rd_mem        <= dec_rd_mem;
      dp_wr_mem        <= dec_wr_mem;
      dp_cond_branch   <= dec_cond;
      dp_uncond_branch <= dec_uncond;
      dp_halt          <= dec_halt;
      dp_illegal       <= dec_illegal;
    end
  end

endmodule

`default_nettype wire

//--- logic/dispatch_credit.sv
// Dispatch credit counter: tracks free back-end slots and steers decode
`timescale 1ns/1ps
`default_nettype none

module dispatch_credit #(
  parameter int CREDITS = frontend_pkg::DEFAULT_CREDITS
) (
  input  logic clock,
  input  logic reset,
  input  logic dp_valid,
  input  logic dp_credit_return,
  output logic credit_available
);

  localparam int CNT_WIDTH = $clog2(CREDITS + 1);

  logic [CNT_WIDTH-1:0] credit_count;

  // A send on the port has not been taken off the count yet
  assign credit_available = credit_count > CNT_WIDTH'(dp_valid);

  always_ff @(posedge clock)
  begin
    if (reset)
      credit_count <= CNT_WIDTH'(CREDITS);
    else
    begin
      case ({dp_valid, dp_credit_return})
        2'b10:   credit_count <= credit_count - 1'b1;  // Send only
        2'b01:   credit_count <= credit_count + 1'b1;  // Return only
        default: credit_count <= credit_count;         // Both cancel, or idle
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/frontend_top.sv
// Front end top level: instruction cache, fetch, decode and dispatch credits
`timescale 1ns/1ps
`default_nettype none

module frontend_top #(
  parameter int CREDITS = frontend_pkg::DEFAULT_CREDITS
) (
  input  logic                                     clock,
  input  logic                                     reset,
  // Memory bus
  input  logic [frontend_pkg::MEM_TAG_WIDTH-1:0]   mem2proc_response,
  input  logic [frontend_pkg::LINE_WIDTH-1:0]      mem2proc_data,
  input  logic [frontend_pkg::MEM_TAG_WIDTH-1:0]   mem2proc_tag,
  output frontend_pkg::bus_cmd_t                   proc2mem_command,
  output logic [frontend_pkg::ADDR_WIDTH-1:0]      proc2mem_addr,
  // Dispatch port
  input  logic                                     dp_credit_return,
  output logic                                     dp_valid,
  output logic [frontend_pkg::ADDR_WIDTH-1:0]      dp_npc,
  output logic [frontend_pkg::INST_WIDTH-1:0]      dp_ir,
  output logic [frontend_pkg::REG_IDX_WIDTH-1:0]   dp_rega_idx,
  output logic [frontend_pkg::REG_IDX_WIDTH-1:0]   dp_regb_idx,
  output logic [frontend_pkg::REG_IDX_WIDTH-1:0]   dp_dest_idx,
  output logic [frontend_pkg::ALU_FUNC_WIDTH-1:0]  dp_alu_func,
  output logic                                     dp_rd_mem,
  output logic                                     dp_wr_mem,
  output logic                                     dp_cond_branch,
  output logic                                     dp_uncond_branch,
  output logic                                     dp_halt,
  output logic                                     dp_illegal
);

  // Cache array hookup
  logic [frontend_pkg::INDEX_WIDTH-1:0] cache_rd_idx, cache_wr_idx;
  logic [frontend_pkg::TAG_WIDTH-1:0]   cache_rd_tag, cache_wr_tag;
  logic [frontend_pkg::LINE_WIDTH-1:0]  cache_rd_data, line_data;
  logic                                 cache_rd_valid, cache_wr_en, line_valid;

  // Fetch and decode
  logic [frontend_pkg::ADDR_WIDTH-1:0]  fetch_addr, if_id_npc;
  logic [frontend_pkg::INST_WIDTH-1:0]  if_id_ir;
  logic                                 if_id_valid, if_id_enable, credit_available;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction cache
  ////////////////////////////////////////////////////////////////////////////

  icache_mem u_icache_mem (
    .clock    (clock),
    .reset    (reset),
    .wr_en    (cache_wr_en),
    .wr_idx   (cache_wr_idx),
    .wr_tag   (cache_wr_tag),
    .wr_data  (mem2proc_data),        // Fill straight off the bus
    .rd_idx   (cache_rd_idx),
    .rd_tag   (cache_rd_tag),
    .rd_data  (cache_rd_data),
    .rd_valid (cache_rd_valid)
  );

  icache_ctrl u_icache_ctrl (
    .clock             (clock),
    .reset             (reset),
    .fetch_addr        (fetch_addr),
    .mem2proc_response (mem2proc_response),
    .mem2proc_tag      (mem2proc_tag),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .cache_rd_idx      (cache_rd_idx),
    .cache_rd_tag      (cache_rd_tag),
    .cache_rd_valid    (cache_rd_valid),
    .cache_rd_data     (cache_rd_data),
    .cache_wr_en       (cache_wr_en),
    .cache_wr_idx      (cache_wr_idx),
    .cache_wr_tag      (cache_wr_tag),
    .line_data         (line_data),
    .line_valid        (line_valid)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline
  ////////////////////////////////////////////////////////////////////////////

  fetch_stage u_fetch (
    .clock        (clock),
    .reset        (reset),
    .line_data    (line_data),
    .line_valid   (line_valid),
    .if_id_enable (if_id_enable),
    .fetch_addr   (fetch_addr),
    .if_id_valid  (if_id_valid),
    .if_id_npc    (if_id_npc),
    .if_id_ir     (if_id_ir)
  );

  decode_stage u_decode (
    .clock            (clock),
    .reset            (reset),
    .if_id_valid      (if_id_valid),
    .if_id_npc        (if_id_npc),
    .if_id_ir         (if_id_ir),
    .credit_available (credit_available),
    .if_id_enable     (if_id_enable),
    .dp_valid         (dp_valid),
    .dp_npc           (dp_npc),
    .dp_ir            (dp_ir),
    .dp_rega_idx      (dp_rega_idx),
    .dp_regb_idx      (dp_regb_idx),
    .dp_dest_idx      (dp_dest_idx),
    .dp_alu_func      (dp_alu_func),
    .dp_rd_mem        (dp_rd_mem),
    .dp_wr_mem        (dp_wr_mem),
    .dp_cond_branch   (dp_cond_branch),
    .dp_uncond_branch (dp_uncond_branch),
    .dp_halt          (dp_halt),
    .dp_illegal       (dp_illegal)
  );

  dispatch_credit #(
    .CREDITS (CREDITS)
  ) u_credit (
    .clock            (clock),
    .reset            (reset),
    .dp_valid         (dp_valid),
    .dp_credit_return (dp_credit_return),
    .credit_available (credit_available)
  );

endmodule

`default_nettype wire

//--- verification/frontend_checker.sv
// Front end checker with bound assertions on reset, dispatch credits and memory bus
`timescale 1ns/1ps
`default_nettype none

module frontend_checker #(
  parameter int CREDITS = frontend_pkg::DEFAULT_CREDITS
) (
  input  logic                                    clock,
  input  logic                                    reset,
  input  logic                                    dp_valid,
  input  logic                                    dp_credit_return,
  input  logic [$clog2(CREDITS + 1)-1:0]          credit_count,
  input  frontend_pkg::bus_cmd_t                  proc2mem_command,
  input  logic [frontend_pkg::ADDR_WIDTH-1:0]     proc2mem_addr,
  input  logic [frontend_pkg::MEM_TAG_WIDTH-1:0]  mem2proc_response
);

  int credits;                          // Sender count rebuilt from the port
  int unsigned reset_fails  = 0;
  int unsigned credit_fails = 0;
  int unsigned bus_fails    = 0;
  int unsigned failures;

  assign failures = reset_fails + credit_fails + bus_fails;

  always_ff @(posedge clock)
  begin
    if (reset)
      credits <= CREDITS;
    else
      credits <= credits - int'(dp_valid) + int'(dp_credit_return);  // Both cancel
  end

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  a_reset_bus: assert property (@(posedge clock)
    reset |-> proc2mem_command == frontend_pkg::BUS_NONE)
    else
    begin
      reset_fails++;
      $error("Bus load issued during reset");
    end

  a_reset_dp: assert property (@(posedge clock) reset |=> !dp_valid)
    else
    begin
      reset_fails++;
      $error("Dispatch valid right after a reset cycle");
    end

  a_no_credit: assert property (@(posedge clock) disable iff (reset)
    dp_valid |-> credits > 0)
    else
    begin
      credit_fails++;
      $error("Dispatch with no credit left");
    end

  // Counter inside the DUT
  a_credit_max: assert property (@(posedge clock) disable iff (reset)
    credit_count <= CREDITS)
    else
    begin
      credit_fails++;
      $error("Credit count above its depth");
    end

  // Busy answer holds the request steady
  a_bus_hold: assert property (@(posedge clock) disable iff (reset)
    (proc2mem_command == frontend_pkg::BUS_LOAD && mem2proc_response == '0)
    |=> (proc2mem_command == frontend_pkg::BUS_LOAD && $stable(proc2mem_addr)))
    else
    begin
      bus_fails++;
      $error("Busy request dropped or its address moved");
    end

endmodule

`default_nettype wire

//--- verification/frontend_tb.sv
// Front end testbench with memory and back-end models, reference decoder and scoreboard
`timescale 1ns/1ps
`default_nettype none

module frontend_tb;

  localparam int CREDITS      = 4;
  localparam int PROG_WORDS   = 512;    // Random program from address 0
  localparam int NUM_DISPATCH = 400;
  localparam int FIRST_LIMIT  = 200;    // Cycles allowed to the first dispatch
  localparam int RUN_LIMIT    = 20000;

  logic                                     clock;
  logic                                     reset;
  logic [frontend_pkg::MEM_TAG_WIDTH-1:0]   mem2proc_response;
  logic [frontend_pkg::MEM_TAG_WIDTH-1:0]   mem2proc_tag;
  logic [frontend_pkg::LINE_WIDTH-1:0]      mem2proc_data;
  frontend_pkg::bus_cmd_t                   proc2mem_command;
  logic [frontend_pkg::ADDR_WIDTH-1:0]      proc2mem_addr;
  logic                                     dp_credit_return;
  logic                                     dp_valid;
  logic [frontend_pkg::ADDR_WIDTH-1:0]      dp_npc;
  logic [frontend_pkg::INST_WIDTH-1:0]      dp_ir;
  logic [frontend_pkg::REG_IDX_WIDTH-1:0]   dp_rega_idx, dp_regb_idx, dp_dest_idx;
  logic [frontend_pkg::ALU_FUNC_WIDTH-1:0]  dp_alu_func;
  logic dp_rd_mem, dp_wr_mem, dp_cond_branch, dp_uncond_branch, dp_halt, dp_illegal;

  logic [31:0]  rng;                    // xorshift state
  logic [31:0]  prog [PROG_WORDS];
  bit           requested [logic [63:0]];  // Lines seen on the bus
  int unsigned  cycle, n_disp, n_returned, errors, hold;
  int unsigned  credit_due [$];         // Cycle each held credit may go back
  logic         fill_pending, was_busy;
  logic [3:0]   fill_tag, next_tag;
  logic [63:0]  fill_addr, busy_addr;
  int unsigned  fill_delay;

  frontend_top #(.CREDITS(CREDITS)) u_dut (.*);

  bind frontend_top frontend_checker #(.CREDITS(CREDITS)) u_checker (
    .clock             (clock),
    .reset             (reset),
    .dp_valid          (dp_valid),
    .dp_credit_return  (dp_credit_return),
    .credit_count      (u_credit.credit_count),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .mem2proc_response (mem2proc_response)
  );

  initial
  begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  function automatic logic [31:0] rand_next();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Program word or a pattern of the full address past the program
  function automatic logic [31:0] mem_word(input logic [63:0] addr);
    if (addr < 64'(4 * PROG_WORDS))
      return prog[addr[10:2]];
    return addr[31:0] ^ addr[63:32] ^ 32'h9e37_79b9;
  endfunction

  function automatic logic [31:0] random_inst();
    logic [31:0] pick;
    logic [31:0] body;
    logic [5:0]  op;
    pick = rand_next();
    body = rand_next();
    case (pick % 12)
      0:
      begin
        op = frontend_pkg::OP_PAL;
        if (pick[8])
          body = '0;                    // Halt about half the time
      end
      1, 2:    op = frontend_pkg::OP_INTOP;
      3:       op = frontend_pkg::OP_LDQ;
      4:       op = frontend_pkg::OP_STQ;
      5:       op = frontend_pkg::OP_BR;
      6, 7:    op = frontend_pkg::OP_BCOND_FIRST + 6'(pick[10:8]);
      default: op = {pick[9:8], 4'h3};  // 03, 13, 23, 33 are unused
    endcase
    return {op, body[25:0]};
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected)
    begin
      errors++;
      $display("ERROR %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  // Flags are rd_mem, wr_mem, cond, uncond, halt, illegal
  task automatic reference_decode(input logic [31:0] ir, output logic [4:0] dest,
                                  output logic [4:0] alu, output logic [5:0] flags);
    logic [5:0] op;
    op    = ir[31:26];
    dest  = frontend_pkg::ZERO_REG;
    alu   = '0;
    flags = '0;
    if (op == frontend_pkg::OP_PAL)
      flags[1:0] = (ir[25:0] == '0) ? 2'b10 : 2'b01;
    else if (op == frontend_pkg::OP_INTOP)
    begin
      dest = ir[4:0];
      alu  = ir[9:5];
    end
    else if (op == frontend_pkg::OP_LDQ)
    begin
      dest     = ir[25:21];
      flags[5] = 1'b1;
    end
    else if (op == frontend_pkg::OP_STQ)
      flags[4] = 1'b1;
    else if (op == frontend_pkg::OP_BR)
    begin
      dest     = ir[25:21];               // Link register
      flags[2] = 1'b1;
    end
    else if (op >= frontend_pkg::OP_BCOND_FIRST)
      flags[3] = 1'b1;
    else
      flags[0] = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Per falling edge the model samples DUT outputs and drives the next inputs
  ////////////////////////////////////////////////////////////////////////////

  task automatic model_step();
    logic [63:0] exp_npc;
    logic [31:0] exp_ir;
    logic [4:0]  exp_dest, exp_alu;
    logic [5:0]  exp_flags;
    cycle++;
    if (fill_pending && proc2mem_command == frontend_pkg::BUS_LOAD)
    begin
      errors++;
      $display("New bus request while fill of line %h is outstanding", fill_addr);
    end
    // Fill return drives tag and data for one cycle
    mem2proc_tag  = '0;
    mem2proc_data = '0;
    if (fill_pending)
    begin
      fill_delay--;
      if (fill_delay == 0)
      begin
        mem2proc_tag  = fill_tag;
        mem2proc_data = {mem_word(fill_addr + 64'd4), mem_word(fill_addr)};
        fill_pending  = 1'b0;
      end
    end
    // Request handshake answered in the same cycle
    mem2proc_response = '0;
    if (proc2mem_command == frontend_pkg::BUS_LOAD)
    begin
      check_value("request alignment", 64'd0, proc2mem_addr & 64'hffff_ffff_0000_0007);
      if (was_busy)
        check_value("busy retry address", busy_addr, proc2mem_addr);
      if (rand_next() % 4 == 0)
      begin
        was_busy  = 1'b1;               // Busy so the same request comes next cycle
        busy_addr = proc2mem_addr;
      end
      else
      begin
        if (requested.exists(proc2mem_addr))
        begin
          errors++;
          $display("Line %h requested a second time", proc2mem_addr);
        end
        requested[proc2mem_addr] = 1'b1;
        mem2proc_response = next_tag;
        fill_tag     = next_tag;
        fill_addr    = proc2mem_addr;
        fill_delay   = 1 + rand_next() % 8;
        fill_pending = 1'b1;
        next_tag     = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;  // Never zero
        was_busy     = 1'b0;
      end
    end
    else if (was_busy)
    begin
      errors++;
      was_busy = 1'b0;
      $display("Busy request for line %h withdrawn before acceptance", busy_addr);
    end
    // Scoreboard in program order
    if (dp_valid === 1'b1)
    begin
      n_disp++;
      exp_npc = 64'(4 * n_disp);
      exp_ir  = mem_word(exp_npc - 64'd4);
      reference_decode(exp_ir, exp_dest, exp_alu, exp_flags);
      check_value("dispatch npc", exp_npc, dp_npc);
      check_value("dispatch ir", 64'(exp_ir), 64'(dp_ir));
      check_value("rega idx", 64'(exp_ir[25:21]), 64'(dp_rega_idx));
      check_value("regb idx", 64'(exp_ir[20:16]), 64'(dp_regb_idx));
      check_value("dest idx", 64'(exp_dest), 64'(dp_dest_idx));
      check_value("alu func", 64'(exp_alu), 64'(dp_alu_func));
      check_value("control flags", 64'(exp_flags), 64'({dp_rd_mem, dp_wr_mem,
                  dp_cond_branch, dp_uncond_branch, dp_halt, dp_illegal}));
      credit_due.push_back(cycle + rand_next() % 7);
      if (n_disp > n_returned + CREDITS)
      begin
        errors++;
        $display("More instructions in flight than credits after dispatch %0d", n_disp);
      end
    end
    // Back end with long holds now and then
    if (hold > 0)
      hold--;
    else if (rand_next() % 64 == 0)
      hold = 16 + rand_next() % 24;
    dp_credit_return = 1'b0;
    if (hold == 0 && credit_due.size() > 0 && credit_due[0] <= cycle)
    begin
      dp_credit_return = 1'b1;
      void'(credit_due.pop_front());
      n_returned++;
    end
  endtask

  initial
  begin
    int unsigned waited;
    int unsigned assert_fails;
    rng               = 32'hd382;
    reset             = 1'b1;
    mem2proc_response = '0;
    mem2proc_tag      = '0;
    mem2proc_data     = '0;
    dp_credit_return  = 1'b0;
    cycle        = 0;
    n_disp       = 0;
    n_returned   = 0;
    errors       = 0;
    hold         = 0;
    fill_pending = 1'b0;
    was_busy     = 1'b0;
    next_tag     = 4'd1;
    for (int i = 0; i < PROG_WORDS; i++)
      prog[i] = random_inst();
    repeat (3) @(negedge clock);
    reset = 1'b0;
    @(negedge clock);
    check_value("first request command", 64'(frontend_pkg::BUS_LOAD), 64'(proc2mem_command));
    check_value("first request address", 64'd0, proc2mem_addr);
    model_step();
    waited = 0;
    while (n_disp == 0 && waited < FIRST_LIMIT)
    begin
      @(negedge clock);
      model_step();
      waited++;
    end
    if (n_disp == 0)
    begin
      errors++;
      $display("Timeout: no instruction dispatched after reset");
    end
    waited = 0;
    while (n_disp < NUM_DISPATCH && waited < RUN_LIMIT)
    begin
      @(negedge clock);
      model_step();
      waited++;
    end
    if (n_disp < NUM_DISPATCH)
    begin
      errors++;
      $display("Timeout: only %0d of %0d instructions dispatched", n_disp, NUM_DISPATCH);
    end
    assert_fails = u_dut.u_checker.failures;
    $display("Errors: %0d testbench, %0d assertion, %0d dispatched", errors, assert_fails,
             n_disp);
    if (errors == 0 && assert_fails == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
common/frontend_pkg.sv
icache/icache_mem.sv
icache/icache_ctrl.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/dispatch_credit.sv
logic/frontend_top.sv
verification/frontend_checker.sv
verification/frontend_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the front end testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module frontend_tb -f vlog.f -o frontend_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see $BUILD_LOG"
  exit 1
fi

./obj_dir/frontend_sim +verilator+error+limit+1000 > "$SIM_LOG" 2>&1
run_status=$?
cat "$SIM_LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "Regression failed" "$SIM_LOG"; then
  exit 1
fi
exit 0
